//--- hw/eeprom_pkg.sv
package eeprom_pkg;

    // device type code of the 24C16 family, upper nibble of the control byte
    localparam logic [3:0] dev_code = 4'b1010;

    // byte-level commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        op_start = 2'd0,    // also used for repeated start
        op_stop  = 2'd1,
        op_write = 2'd2,    // send byte, sample slave ack
        op_read  = 2'd3     // receive byte, send given ack bit
    } twi_op_t;

    typedef struct packed {
        logic [2:0] block;  // goes into the control byte
        logic [7:0] word;   // sent as the word address
    } eeprom_addr_s;

    // 11-bit array address, either flat or split into block and word
    typedef union packed {
        logic [10:0]  flat;
        eeprom_addr_s split;
    } eeprom_addr_u;

endpackage

//--- hw/twi_cmd_if.sv
interface twi_cmd_if import eeprom_pkg::*; (
    input logic CLK,
    input logic RESET
);

    logic       cmd_valid;   // one cycle strobe
    twi_op_t    cmd_op;
    logic [7:0] tx_byte;
    logic       tx_ack_bit;  // ack bit sent after op_read
    logic       done;        // one pulse per command
    logic [7:0] rx_byte;
    logic       rx_ack;      // high means the slave did not acknowledge

    modport seq (
        input  CLK, RESET,
        input  done, rx_byte, rx_ack,
        output cmd_valid, cmd_op, tx_byte, tx_ack_bit
    );

    modport engine (
        input  CLK, RESET,
        input  cmd_valid, cmd_op, tx_byte, tx_ack_bit,
        output done, rx_byte, rx_ack
    );

endinterface

//--- hw/eeprom_seq.sv
module eeprom_seq import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        ack,
    output logic        nack,
    output logic        busy,
    twi_cmd_if.seq      bus
);

    // one-hot state indices
    localparam int s_idle    = 0;
    localparam int s_start   = 1;
    localparam int s_ctrl_wr = 2;
    localparam int s_addr    = 3;
    localparam int s_data_wr = 4;
    localparam int s_restart = 5;
    localparam int s_ctrl_rd = 6;
    localparam int s_data_rd = 7;
    localparam int s_stop    = 8;
    localparam int s_done    = 9;

    logic [9:0]   state;
    logic [9:0]   nxt;
    eeprom_addr_u req;
    logic [7:0]   wbuf;
    logic         is_read;
    logic         accept;
    logic         advance;
    logic         byte_sent;
    logic         dev_nack;

    function automatic logic [9:0] onehot(input int idx);
        logic [9:0] v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    assign accept    = state[s_idle] & (wr | rd);
    assign busy      = ~state[s_idle];
    assign ack       = state[s_done];

    // states whose command sends a byte the device must acknowledge
    assign byte_sent = state[s_ctrl_wr] | state[s_addr] | state[s_data_wr] | state[s_ctrl_rd];
    assign dev_nack  = bus.done & byte_sent & bus.rx_ack;
    assign advance   = accept | bus.done | state[s_done];

    always_comb begin
        nxt = state;
        case (1'b1)
            state[s_idle]:    nxt = onehot(s_start);
            state[s_start]:   nxt = onehot(s_ctrl_wr);
            state[s_ctrl_wr]: nxt = dev_nack ? onehot(s_stop) : onehot(s_addr);
            state[s_addr]: begin
                if (dev_nack)
                    nxt = onehot(s_stop);
                else if (is_read)
                    nxt = onehot(s_restart);
                else
                    nxt = onehot(s_data_wr);
            end
            state[s_data_wr]: nxt = onehot(s_stop);
            state[s_restart]: nxt = onehot(s_ctrl_rd);
            state[s_ctrl_rd]: nxt = dev_nack ? onehot(s_stop) : onehot(s_data_rd);
            state[s_data_rd]: nxt = onehot(s_stop);
            state[s_stop]:    nxt = onehot(s_done);
            state[s_done]:    nxt = onehot(s_idle);
            default:          nxt = onehot(s_idle);
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= onehot(s_idle);
            bus.cmd_valid <= 1'b0;
            nack          <= 1'b0;
        end else begin
            bus.cmd_valid <= 1'b0;
            if (advance) begin
                state         <= nxt;
                bus.cmd_valid <= ~(nxt[s_idle] | nxt[s_done]);   // every other state is a command
            end
            if (accept)
                nack <= 1'b0;
            else if (dev_nack)
                nack <= 1'b1;
        end
    end

    // request capture and read data
    always_ff @(posedge CLK) begin
        if (accept) begin
            req.flat <= addr;
            wbuf     <= wdata;
            is_read  <= ~wr;   // wr wins over rd
        end
        if (state[s_data_rd] && bus.done)
            rdata <= bus.rx_byte;
    end

    // command fields follow the state, stable while the command is outstanding
    always_comb begin
        bus.cmd_op  = op_write;
        bus.tx_byte = {dev_code, req.split.block, 1'b0};
        case (1'b1)
            state[s_start], state[s_restart]: bus.cmd_op = op_start;
            state[s_stop]:    bus.cmd_op = op_stop;
            state[s_addr]:    bus.tx_byte = req.split.word;
            state[s_data_wr]: bus.tx_byte = wbuf;
            state[s_ctrl_rd]: bus.tx_byte = {dev_code, req.split.block, 1'b1};
            state[s_data_rd]: bus.cmd_op = op_read;
            default: ;
        endcase
    end

    // single byte read ends with a master nack
    assign bus.tx_ack_bit = state[s_data_rd];

endmodule

//--- hw/twi_bit_engine.sv
module twi_bit_engine import eeprom_pkg::*; #(
    parameter int CLK_DIV = 2
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      sda_in,
    output logic      scl,
    output logic      sda_pull,
    twi_cmd_if.engine bus
);

    localparam int            cw       = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [cw-1:0] cnt_last = cw'(CLK_DIV - 1);

    logic          active;
    twi_op_t       op;
    logic [4:0]    hp;        // half period within the command
    logic [4:0]    hp_last;
    logic [cw-1:0] cnt;
    logic          tick;
    logic          byte_op;
    logic [7:0]    tx_sh;
    logic [7:0]    rx_sh;
    logic          ack_bit;
    logic          sda_drv;   // next sda_pull, retimed half a clock later

    always_comb begin
        case (op)
            op_start: hp_last = 5'd1;
            op_stop:  hp_last = 5'd2;
            default:  hp_last = 5'd17;   // 8 bits plus ack
        endcase
    end

    assign byte_op     = (op == op_write) || (op == op_read);
    assign tick        = (cnt == cnt_last);
    assign bus.done    = active & tick & (hp == hp_last);
    assign bus.rx_byte = rx_sh;

    // half period pacing
    always_ff @(posedge CLK) begin
        if (RESET || !active || tick)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // phase state machine, scl and the sda level per half period
    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            hp      <= '0;
            scl     <= 1'b1;
            sda_drv <= 1'b0;
        end else if (!active) begin
            if (bus.cmd_valid) begin
                active <= 1'b1;
                hp     <= '0;
                case (bus.cmd_op)
                    op_start: begin
                        scl     <= 1'b1;          // sda already released
                        sda_drv <= 1'b0;
                    end
                    op_stop: begin
                        scl     <= 1'b0;
                        sda_drv <= 1'b1;
                    end
                    op_write: begin
                        scl     <= 1'b0;
                        sda_drv <= ~bus.tx_byte[7];   // msb first
                    end
                    default: begin
                        scl     <= 1'b0;
                        sda_drv <= 1'b0;
                    end
                endcase
            end
        end else if (tick) begin
            if (hp == hp_last) begin
                active <= 1'b0;
                scl    <= (op == op_stop);   // bus left idle only after stop
            end else begin
                hp <= hp + 1'b1;
                case (op)
                    op_start: sda_drv <= 1'b1;   // sda falls while scl high
                    op_stop: begin
                        if (hp == 5'd0)
                            scl <= 1'b1;
                        else
                            sda_drv <= 1'b0;     // sda rises while scl high
                    end
                    default: begin
                        if (!hp[0]) begin
                            scl <= 1'b1;
                        end else begin
                            scl <= 1'b0;
                            if (hp == 5'd15)
                                sda_drv <= (op == op_read) && !ack_bit;   // ack slot
                            else if (op == op_write)
                                sda_drv <= ~tx_sh[6];
                            else
                                sda_drv <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // byte shifters, sampling where scl rises
    always_ff @(posedge CLK) begin
        if (!active && bus.cmd_valid) begin
            op      <= bus.cmd_op;
            tx_sh   <= bus.tx_byte;
            ack_bit <= bus.tx_ack_bit;
        end else if (active && tick && hp != hp_last && byte_op) begin
            if (hp[0]) begin
                tx_sh <= tx_sh << 1;
            end else if (hp == 5'd16) begin
                bus.rx_ack <= sda_in;
            end else if (op == op_read) begin
                rx_sh <= {rx_sh[6:0], sda_in};
            end
        end
    end

    // sda moves half a clock after scl so it never changes on an scl edge
    always_ff @(negedge CLK) begin
        if (RESET)
            sda_pull <= 1'b0;
        else
            sda_pull <= sda_drv;
    end

endmodule

//--- hw/eeprom_host_top.sv
module eeprom_host_top #(
    parameter int CLK_DIV = 2   // CLK cycles per scl half period
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        ack,
    output logic        nack,
    output logic        busy,
    output logic        scl,
    inout  wire         sda
);

    logic sda_pull;
    logic sda_in;

    twi_cmd_if bus_if (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_seq eeprom_seq_inst (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .busy  (busy),
        .bus   (bus_if.seq)
    );

    twi_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) twi_bit_engine_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .sda_in   (sda_in),
        .scl      (scl),
        .sda_pull (sda_pull),
        .bus      (bus_if.engine)
    );

    // open drain pad, pull-up is external
    assign sda    = sda_pull ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

//--- dv/eeprom_model.sv
module eeprom_model import eeprom_pkg::*; (
    input logic scl,
    inout wire  sda,
    input logic respond   // low: ignore the bus entirely
);

    localparam int m_idle  = 0;
    localparam int m_ctrl  = 1;
    localparam int m_addr  = 2;
    localparam int m_wdata = 3;
    localparam int m_rdata = 4;
    localparam int m_wait  = 5;   // rest of the transfer ignored until stop

    logic [7:0]   mem [0:2047];
    eeprom_addr_u ptr;
    logic [7:0]   shreg;
    logic [7:0]   tx_sh;
    int           st;
    int           nxt_st;
    int           bit_cnt;
    logic         sda_low;
    logic         scl_q;
    logic         sda_q;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h3c;
        st      = m_idle;
        nxt_st  = m_idle;
        bit_cnt = 0;
        sda_low = 1'b0;
        scl_q   = 1'b1;
        sda_q   = 1'b1;
    end

    assign sda = sda_low ? 1'b0 : 1'bz;

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            st      = respond ? m_ctrl : m_idle;   // start or repeated start
            bit_cnt = 0;
            sda_low = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            st      = m_idle;   // stop
            sda_low = 1'b0;
        end else if (scl_q === 1'b0 && scl === 1'b1 && st != m_idle) begin
            shreg   = {shreg[6:0], sda === 1'b1};
            bit_cnt = bit_cnt + 1;
        end else if (scl_q === 1'b1 && scl === 1'b0 && st != m_idle && st != m_wait) begin
            if (bit_cnt == 8) begin
                if (st == m_rdata) begin
                    sda_low = 1'b0;   // master answers this byte
                end else if (st == m_ctrl) begin
                    if (shreg[7:4] == dev_code) begin
                        ptr.split.block = shreg[3:1];
                        nxt_st  = shreg[0] ? m_rdata : m_addr;
                        sda_low = 1'b1;
                    end else begin
                        st = m_wait;
                    end
                end else if (st == m_addr) begin
                    ptr.split.word = shreg;
                    nxt_st  = m_wdata;
                    sda_low = 1'b1;
                end else begin
                    mem[ptr.flat] = shreg;
                    nxt_st  = m_wait;   // single byte writes only
                    sda_low = 1'b1;
                end
            end else if (bit_cnt == 9) begin
                sda_low = 1'b0;
                bit_cnt = 0;
                if (st == m_rdata) begin
                    st = m_wait;   // no sequential reads
                end else begin
                    st = nxt_st;
                    if (st == m_rdata) begin
                        tx_sh   = mem[ptr.flat];
                        sda_low = ~tx_sh[7];
                    end
                end
            end else if (st == m_rdata) begin
                sda_low = ~tx_sh[7 - bit_cnt];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- dv/eeprom_host_chk.sv
module eeprom_host_chk (
    input logic CLK,
    input logic RESET,
    input logic wr,
    input logic rd,
    input logic ack,
    input logic busy,
    input logic scl
);

    int fail_count = 0;

    ack_single: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else begin
            fail_count++;
            $error("ack held high for two cycles");
        end

    ack_busy: assert property (@(posedge CLK) disable iff (RESET) ack |-> busy)
        else begin
            fail_count++;
            $error("ack pulsed while busy was low");
        end

    scl_idle: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl)
        else begin
            fail_count++;
            $error("scl low while the controller is idle");
        end

    busy_start: assert property (@(posedge CLK) disable iff (RESET)
        $rose(busy) |-> $past(!busy && (wr || rd)))
        else begin
            fail_count++;
            $error("busy rose without an accepted strobe");
        end

endmodule

bind eeprom_host_top eeprom_host_chk eeprom_host_chk_inst (.*);

//--- dv/eeprom_host_tb.sv
module eeprom_host_tb import eeprom_pkg::*; ;

    localparam int clk_div     = 2;
    localparam int num_txn     = 69;
    localparam int cycle_limit = num_txn * 7 * 20 * clk_div + 200;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic        respond;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        ack;
    logic        nack;
    logic        busy;
    logic        scl;
    wire         sda;

    logic [7:0] shadow [0:2047];
    logic [9:0] exp_q [$];   // {rdata checked, nack, rdata}
    logic [7:0] last_rdata;
    logic       rdata_known;
    int         errors    = 0;
    int         checks    = 0;
    int         issued    = 0;
    int         acks_seen = 0;
    int         cycles    = 0;

    pullup (sda);

    eeprom_host_top #(
        .CLK_DIV (clk_div)
    ) eeprom_host_top_inst (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .busy  (busy),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model eeprom_model_inst (
        .scl     (scl),
        .sda     (sda),
        .respond (respond)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [7:0] exp_read(input logic [10:0] a);
        return shadow[a];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    // start a transaction and queue what its ack must carry
    task automatic issue(input logic do_wr, input logic do_rd, input logic [10:0] a,
                         input logic [7:0] d);
        do @(negedge CLK); while (busy);
        @(posedge CLK);
        wr    <= do_wr;
        rd    <= do_rd;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        if (!do_wr && respond) begin
            last_rdata  = exp_read(a);
            rdata_known = 1'b1;
        end
        if (do_wr && respond)
            shadow[a] = d;
        exp_q.push_back({rdata_known, !respond, last_rdata});
        issued++;
    endtask

    // strobe during a running transaction, must have no effect
    task automatic poke(input logic do_wr, input logic [10:0] a, input logic [7:0] d);
        do @(negedge CLK); while (!busy);
        @(posedge CLK);
        wr    <= do_wr;
        rd    <= !do_wr;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_idle;
        while (acks_seen < issued)
            @(negedge CLK);
    endtask

    initial begin
        logic [9:0] e;
        forever begin
            @(negedge CLK);
            if (ack === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("error: ack pulse arrived with no request outstanding");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_val("nack", e[8], nack);
                    if (e[9])
                        check_val("rdata", e[7:0], rdata);
                end
                acks_seen++;
            end
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("%0d checks, %0d errors", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        eeprom_addr_u a;
        logic [7:0]   d;
        void'($urandom(22));
        for (int k = 0; k < 2048; k++)
            shadow[k] = 8'(k) ^ 8'(k >> 3) ^ 8'h3c;   // same fill as the model
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        respond     = 1'b1;
        RESET       = 1'b1;
        last_rdata  = '0;
        rdata_known = 1'b0;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;

        @(negedge CLK);
        check_val("ack", 0, ack);
        check_val("busy", 0, busy);
        check_val("nack", 0, nack);
        check_val("scl", 1, scl);
        check_val("sda", 1, sda);

        issue(1'b1, 1'b0, 11'h2a5, 8'h6e);
        wait_idle();
        issue(1'b0, 1'b1, 11'h2a5, 8'h00);
        wait_idle();

        for (int i = 0; i < 30; i++) begin
            a.split.block = 3'(i);   // walks all eight blocks
            a.split.word  = 8'($urandom);
            d             = 8'($urandom);
            issue(1'b1, 1'b0, a.flat, d);
            wait_idle();
            if ($urandom % 2)
                a.flat = 11'($urandom);
            issue(1'b0, 1'b1, a.flat, 8'h00);
            wait_idle();
        end

        // device silent
        @(posedge CLK);
        respond <= 1'b0;
        a.flat = 11'h7f3;
        issue(1'b1, 1'b0, a.flat, ~exp_read(a.flat));
        wait_idle();
        issue(1'b0, 1'b1, a.flat, 8'h00);
        wait_idle();
        @(posedge CLK);
        respond <= 1'b1;
        issue(1'b0, 1'b1, a.flat, 8'h00);
        wait_idle();

        issue(1'b1, 1'b0, 11'h135, 8'hc4);
        poke(1'b1, 11'h135, 8'h3b);
        poke(1'b0, 11'h400, 8'h00);
        wait_idle();
        issue(1'b1, 1'b1, 11'h5e1, 8'h92);   // wr and rd together, wr wins
        poke(1'b0, 11'h135, 8'h00);
        wait_idle();
        issue(1'b0, 1'b1, 11'h135, 8'h00);
        wait_idle();
        issue(1'b0, 1'b1, 11'h5e1, 8'h00);
        wait_idle();

        repeat (20) @(negedge CLK);
        if (exp_q.size() != 0) begin
            $display("error: %0d requests never answered with ack", exp_q.size());
            errors++;
        end
        errors += eeprom_host_top_inst.eeprom_host_chk_inst.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- build.f
hw/eeprom_pkg.sv
hw/twi_cmd_if.sv
hw/eeprom_seq.sv
hw/twi_bit_engine.sv
hw/eeprom_host_top.sv
dv/eeprom_model.sv
dv/eeprom_host_chk.sv
dv/eeprom_host_tb.sv
